//--- run.sh
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sfir_tb -f src.f -o sfir_sim &&
    ./obj_dir/sfir_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

//--- source/sfir_coef_pkg.sv
`default_nettype none

`include "sfir_defines.svh"

package sfir_coef_pkg;

    // Entries in the table below
    localparam int COEF_TABLE_LEN = 4;

    // One coefficient per pair, tap j and its mirror share COEF[j]
    localparam sfir_types_pkg::coef_t COEF [COEF_TABLE_LEN] = '{
        16'sh0400,
        16'shF000,
        16'sh2000,
        16'sh3A00
    };

    // Set when the table does not cover the configured tap count
    localparam bit TAP_NUM_MISMATCH = (COEF_TABLE_LEN != `SFIR_TAP_NUM);

endpackage

`default_nettype wire

//--- source/sfir_defines.svh
`ifndef SFIR_DEFINES_SVH
`define SFIR_DEFINES_SVH

// Number of coefficient pairs, the filter length is twice this
`define SFIR_TAP_NUM 4

`define SFIR_DATA_WIDTH 16
`define SFIR_COEF_WIDTH 16

// Sample times coefficient, one bit of pre-add growth, three guard bits for the cascade
`define SFIR_PRODUCT_WIDTH (`SFIR_DATA_WIDTH + `SFIR_COEF_WIDTH + 1 + 3)

// Depth that places the mirrored taps right after the head taps
`define SFIR_TAIL_DELAY (2 * `SFIR_TAP_NUM - 1)

// Enabled samples from data_i to the first tap of the core sum
`define SFIR_CORE_LATENCY (`SFIR_TAP_NUM + 3)

// Right shift applied to the cascade sum ahead of rounding
`define SFIR_OUT_SHIFT 15

`endif

//--- source/sfir_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfir_defines.svh"

module sfir_filter_top (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              en_i,
    input  logic signed [`SFIR_DATA_WIDTH-1:0] data_i,
    output logic signed [`SFIR_DATA_WIDTH-1:0] data_o,
    output logic                              sat_o,
    output logic                              valid_o
);

    // Full precision sum between the array and the output stage
    sfir_types_pkg::product_t core_sum;

    sfir_systolic_core i_core (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (en_i),
        .data_i (data_i),
        .sum_o  (core_sum)
    );

    sfir_output_stage i_output_stage (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (en_i),
        .sum_i  (core_sum),
        .data_o (data_o),
        .sat_o  (sat_o),
        .valid_o(valid_o)
    );

endmodule

`default_nettype wire

//--- source/sfir_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfir_defines.svh"

module sfir_output_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  sfir_types_pkg::product_t sum_i,
    output sfir_types_pkg::sample_t  data_o,
    output logic                     sat_o,
    output logic                     valid_o
);

    localparam int DW         = `SFIR_DATA_WIDTH;
    localparam int EW         = `SFIR_PRODUCT_WIDTH + 1;
    localparam int RW         = EW - `SFIR_OUT_SHIFT;
    localparam int FILL_COUNT = `SFIR_CORE_LATENCY + `SFIR_TAIL_DELAY + 1;
    localparam int CNT_W      = $clog2(FILL_COUNT + 1);

    localparam sfir_types_pkg::sample_t SAMPLE_MAX = {1'b0, {(DW - 1){1'b1}}};
    localparam sfir_types_pkg::sample_t SAMPLE_MIN = {1'b1, {(DW - 1){1'b0}}};
    localparam logic signed [RW-1:0]    RND_MAX    = RW'(SAMPLE_MAX);
    localparam logic signed [RW-1:0]    RND_MIN    = RW'(SAMPLE_MIN);
    localparam logic signed [EW-1:0]    HALF_LSB   = EW'(1) << (`SFIR_OUT_SHIFT - 1);

    logic signed [EW-1:0]    biased;
    logic signed [RW-1:0]    rounded;
    sfir_types_pkg::sample_t clipped;
    logic                    clip;
    logic [CNT_W-1:0]        fill_cnt_q;

    // Round half up, then clip to the sample range
    always_comb begin
        biased  = EW'(sum_i) + HALF_LSB;
        rounded = biased[EW-1:`SFIR_OUT_SHIFT];
        clipped = rounded[DW-1:0];
        clip    = 1'b0;
        if (rounded > RND_MAX) begin
            clipped = SAMPLE_MAX;
            clip    = 1'b1;
        end else if (rounded < RND_MIN) begin
            clipped = SAMPLE_MIN;
            clip    = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_o <= '0;
            sat_o  <= 1'b0;
        end else if (en_i) begin
            data_o <= clipped;
            sat_o  <= clip;
        end
    end

    // Counts enabled samples until the pipeline holds only real data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fill_cnt_q <= '0;
        end else if (en_i && !valid_o) begin
            fill_cnt_q <= fill_cnt_q + CNT_W'(1);
        end
    end

    assign valid_o = (fill_cnt_q == CNT_W'(FILL_COUNT));

    a_sat_at_limit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        sat_o |-> (data_o == SAMPLE_MAX) || (data_o == SAMPLE_MIN)
    ) else $error("sat_o high with data_o %h inside range", data_o);

    a_valid_sticky: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o |=> valid_o
    ) else $error("valid_o fell without reset");

endmodule

`default_nettype wire

//--- source/sfir_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module sfir_shift_reg #(
    parameter int DELAY = 1
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    en_i,
    input  sfir_types_pkg::sample_t data_i,
    output sfir_types_pkg::sample_t tail_o
);

    sfir_types_pkg::sample_t [DELAY-1:0] line_q;

    if (DELAY < 1) begin : g_delay_check
        $error("sfir_shift_reg needs DELAY of 1 or more");
    end

    // Tail is DELAY samples older than the newest entry of the line
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_q <= '0;
            tail_o <= '0;
        end else if (en_i) begin
            line_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                line_q[i] <= line_q[i-1];
            end
            tail_o <= line_q[DELAY-1];
        end
    end

    a_hold_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !en_i |=> $stable(line_q) && $stable(tail_o)
    ) else $error("sfir_shift_reg moved while en_i was low");

endmodule

`default_nettype wire

//--- source/sfir_systolic_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfir_defines.svh"

module sfir_systolic_core (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  sfir_types_pkg::sample_t  data_i,
    output sfir_types_pkg::product_t sum_o
);

    sfir_types_pkg::sample_t  tail;
    sfir_types_pkg::sample_t  casc_data [`SFIR_TAP_NUM];
    sfir_types_pkg::product_t casc_sum  [`SFIR_TAP_NUM];

    if (sfir_coef_pkg::TAP_NUM_MISMATCH) begin : g_tap_check
        $error("coefficient table length differs from SFIR_TAP_NUM");
    end

    // Mirrored sample shared by every element
    sfir_shift_reg #(
        .DELAY(`SFIR_TAIL_DELAY)
    ) i_tail_delay (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (en_i),
        .data_i (data_i),
        .tail_o (tail)
    );

    for (genvar i = 0; i < `SFIR_TAP_NUM; i++) begin : g_element
        sfir_types_pkg::sample_t  head_in;
        sfir_types_pkg::product_t sum_in;

        if (i == 0) begin : g_first
            // First element starts the cascade from zero
            assign head_in = data_i;
            assign sum_in  = '0;
        end else begin : g_next
            assign head_in = casc_data[i-1];
            assign sum_in  = casc_sum[i-1];
        end

        sfir_systolic_element i_element (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .en_i       (en_i),
            .coef_i     (sfir_coef_pkg::COEF[i]),
            .data_i     (head_in),
            .tail_i     (tail),
            .casc_data_o(casc_data[i]),
            .casc_sum_i (sum_in),
            .casc_sum_o (casc_sum[i])
        );
    end

    assign sum_o = casc_sum[`SFIR_TAP_NUM-1];

endmodule

`default_nettype wire

//--- source/sfir_systolic_element.sv
`timescale 1ns/1ps
`default_nettype none

module sfir_systolic_element (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  sfir_types_pkg::coef_t    coef_i,
    input  sfir_types_pkg::sample_t  data_i,
    input  sfir_types_pkg::sample_t  tail_i,
    output sfir_types_pkg::sample_t  casc_data_o,
    input  sfir_types_pkg::product_t casc_sum_i,
    output sfir_types_pkg::product_t casc_sum_o
);

    sfir_types_pkg::sample_t  head_q;
    sfir_types_pkg::preadd_t  preadd_q;
    sfir_types_pkg::product_t mult_q;

    // Head sample takes two registers per element
    // while the sum takes one, which walks the taps apart
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q      <= '0;
            casc_data_o <= '0;
        end else if (en_i) begin
            head_q      <= data_i;
            casc_data_o <= head_q;
        end
    end

    // Symmetric pair shares one multiply
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            preadd_q <= '0;
        end else if (en_i) begin
            preadd_q <= sfir_types_pkg::preadd_t'(head_q)
                      + sfir_types_pkg::preadd_t'(tail_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mult_q <= '0;
        end else if (en_i) begin
            mult_q <= sfir_types_pkg::product_t'(preadd_q)
                    * sfir_types_pkg::product_t'(coef_i);
        end
    end

    // Guard bits in product_t leave room for the whole cascade
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            casc_sum_o <= '0;
        end else if (en_i) begin
            casc_sum_o <= mult_q + casc_sum_i;
        end
    end

    a_sum_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !en_i |=> $stable(casc_sum_o)
    ) else $error("casc_sum_o changed while en_i was low");

endmodule

`default_nettype wire

//--- source/sfir_types_pkg.sv
`default_nettype none

`include "sfir_defines.svh"

package sfir_types_pkg;

    // Input and output sample
    typedef logic signed [`SFIR_DATA_WIDTH-1:0] sample_t;

    typedef logic signed [`SFIR_COEF_WIDTH-1:0] coef_t;

    // Head plus tail sample, one bit wider than a sample
    typedef logic signed [`SFIR_DATA_WIDTH:0] preadd_t;

    // Full precision partial sum along the cascade
    typedef logic signed [`SFIR_PRODUCT_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+source
source/sfir_types_pkg.sv
source/sfir_coef_pkg.sv
source/sfir_shift_reg.sv
source/sfir_systolic_element.sv
source/sfir_systolic_core.sv
source/sfir_output_stage.sv
source/sfir_filter_top.sv
test/sfir_tb.sv

//--- test/sfir_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfir_defines.svh"

module sfir_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int FILL_LEN       = 20;
    localparam int IMPULSE_TAIL   = 24;
    localparam int FULL_SCALE_LEN = 24;
    localparam int RANDOM_LEN     = 300;
    localparam int GAP_CYCLES     = 300;
    localparam int IDLE_END       = 4;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 1 + FILL_LEN + 1 + IMPULSE_TAIL
                                  + 2 * FULL_SCALE_LEN + RANDOM_LEN + GAP_CYCLES + IDLE_END;
    localparam int WATCHDOG_NS    = TOTAL_CYCLES * CLK_PERIOD * 2;

    // Enabled samples until the oldest tap holds a real sample
    localparam int FILL_COUNT = `SFIR_CORE_LATENCY + 2 * `SFIR_TAP_NUM - 1 + 1;

    localparam longint OUT_MAX = (longint'(1) <<< (`SFIR_DATA_WIDTH - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (`SFIR_DATA_WIDTH - 1));

    localparam sfir_types_pkg::sample_t POS_FULL = 16'sh7FFF;
    localparam sfir_types_pkg::sample_t NEG_FULL = 16'sh8000;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    en_i;
    sfir_types_pkg::sample_t data_i;
    sfir_types_pkg::sample_t data_o;
    logic                    sat_o;
    logic                    valid_o;

    sfir_types_pkg::sample_t hist[$];
    sfir_types_pkg::sample_t exp_data;
    logic                    exp_sat;
    logic                    exp_valid;
    longint                  y_full;
    logic [31:0]             rng_state  = 32'h872d_cfa8;

    sfir_filter_top i_sfir_filter_top (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .en_i   (en_i),
        .data_i (data_i),
        .data_o (data_o),
        .sat_o  (sat_o),
        .valid_o(valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Samples before reset count as zero
    function automatic longint sample_at(input int idx);
        if (idx < 0) begin
            return 0;
        end
        return longint'(hist[idx]);
    endfunction

    // Full precision sum of the symmetric filter for enabled sample k
    function automatic longint filter_sum(input int k);
        longint acc;
        int     base;
        acc  = 0;
        base = k - `SFIR_CORE_LATENCY;
        for (int j = 0; j < `SFIR_TAP_NUM; j++) begin
            acc += longint'(sfir_coef_pkg::COEF[j])
                 * (sample_at(base - j) + sample_at(base - (2 * `SFIR_TAP_NUM - 1 - j)));
        end
        return acc;
    endfunction

    // Round half up after the output shift
    function automatic longint scale_round(input longint acc);
        return (acc + (longint'(1) <<< (`SFIR_OUT_SHIFT - 1))) >>> `SFIR_OUT_SHIFT;
    endfunction

    // Reference model that advances only on enabled samples
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist.delete();
            exp_data  <= '0;
            exp_sat   <= 1'b0;
            exp_valid <= 1'b0;
        end else if (en_i) begin
            hist.push_back(data_i);
            y_full = scale_round(filter_sum(hist.size() - 1));
            if (y_full > OUT_MAX) begin
                exp_data <= POS_FULL;
                exp_sat  <= 1'b1;
            end else if (y_full < OUT_MIN) begin
                exp_data <= NEG_FULL;
                exp_sat  <= 1'b1;
            end else begin
                exp_data <= sfir_types_pkg::sample_t'(y_full);
                exp_sat  <= 1'b0;
            end
            exp_valid <= (hist.size() >= FILL_COUNT);
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk_i) !rst_n_i |-> (data_o == '0) && !sat_o && !valid_o
    ) else begin
        $display("Error: in reset data_o is %h, sat_o is %h, valid_o is %h, all expected 0",
                 $sampled(data_o), $sampled(sat_o), $sampled(valid_o));
        stop_on_failure();
    end

    a_data_match: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        data_o == exp_data
    ) else begin
        $display("Error: data_o is %h, expected %h", $sampled(data_o), $sampled(exp_data));
        stop_on_failure();
    end

    a_sat_match: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        sat_o == exp_sat
    ) else begin
        $display("Error: sat_o is %h, expected %h", $sampled(sat_o), $sampled(exp_sat));
        stop_on_failure();
    end

    a_valid_match: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o == exp_valid
    ) else begin
        $display("Error: valid_o is %h, expected %h", $sampled(valid_o), $sampled(exp_valid));
        stop_on_failure();
    end

    a_hold_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !en_i |=> $stable(data_o) && $stable(sat_o) && $stable(valid_o)
    ) else begin
        $display("Outputs changed while en_i was low, data_o is now %h", $sampled(data_o));
        stop_on_failure();
    end

    // One clock of stimulus applied just after the rising edge
    task automatic drive_cycle(input logic en, input sfir_types_pkg::sample_t value);
        en_i   = en;
        data_i = value;
        @(posedge clk_i);
        #1;
    endtask

    task automatic fill_pipeline();
        repeat (FILL_LEN) drive_cycle(1'b1, '0);
    endtask

    task automatic send_impulse();
        drive_cycle(1'b1, POS_FULL);
        repeat (IMPULSE_TAIL) drive_cycle(1'b1, '0);
    endtask

    task automatic drive_full_scale();
        repeat (FULL_SCALE_LEN) drive_cycle(1'b1, POS_FULL);
        repeat (FULL_SCALE_LEN) drive_cycle(1'b1, NEG_FULL);
    endtask

    task automatic stream_random();
        for (int i = 0; i < RANDOM_LEN; i++) begin
            rng_state = next_random(rng_state);
            drive_cycle(1'b1, rng_state[31:16]);
        end
    endtask

    // About one cycle in four has en_i low
    task automatic insert_enable_gaps();
        for (int i = 0; i < GAP_CYCLES; i++) begin
            rng_state = next_random(rng_state);
            drive_cycle(rng_state[1:0] != 2'b00, rng_state[31:16]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin
        rst_n_i = 1'b1;
        en_i    = 1'b0;
        data_i  = '0;
        #1;
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        fill_pipeline();
        send_impulse();
        drive_full_scale();
        stream_random();
        insert_enable_gaps();
        repeat (IDLE_END) drive_cycle(1'b0, '0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
